/* include/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// data and address width
`define FETCH_XLEN 32

// fetch queue entries
`define FETCH_QUEUE_DEPTH 4

// bridge timing in clock cycles
`define FETCH_GRANT_CYCLES 2
`define FETCH_WAIT_CYCLES 2

// control word bit positions
`define FETCH_CTRL_START_BIT 0
`define FETCH_CTRL_RESET_BIT 1

// pc step per instruction
`define FETCH_INSTR_BYTES 4

`endif

/* source/fetch_pkg.sv */
`default_nettype none
`include "fetch_defs.svh"

package fetch_pkg;

    // only JAL gets resolved here
    typedef enum logic [6:0] {
        OPC_JAL   = 7'b1101111,
        OPC_OTHER = 7'b0000000
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        STOPPED
    } run_state_e;

    // wishbone classic master side
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic [`FETCH_XLEN-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`FETCH_XLEN-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] instr;
    } fetch_item_t;

    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* source/run_control.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_defs.svh"

module run_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`FETCH_XLEN-1:0] ctrl_i,
    input  logic                   retire_fire_i,
    input  logic                   success_hit_i,
    output logic                   core_reset_o,
    output logic                   run_en_o,
    output logic                   stop_o,
    output logic [`FETCH_XLEN-1:0] cycle_count_o
);
    import fetch_pkg::*;

    logic [`FETCH_XLEN-1:0] ctrl_prev_q;
    logic                   start_q;
    logic                   soft_q;
    logic                   core_reset_q;
    logic [`FETCH_XLEN-1:0] count_q;
    run_state_e             state_q;

    // rising edges of the control bits become one-cycle pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_prev_q <= '0;
            start_q     <= 1'b0;
            soft_q      <= 1'b0;
        end else begin
            ctrl_prev_q <= ctrl_i;
            start_q     <= ctrl_i[`FETCH_CTRL_START_BIT] & ~ctrl_prev_q[`FETCH_CTRL_START_BIT];
            soft_q      <= ctrl_i[`FETCH_CTRL_RESET_BIT] & ~ctrl_prev_q[`FETCH_CTRL_RESET_BIT];
        end
    end

    // core reset for the rest of the front end
    always_ff @(posedge clk) begin
        core_reset_q <= reset | soft_q;
    end

    always_ff @(posedge clk) begin
        if (reset || soft_q) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_q) begin
                        state_q <= RUN;
                    end
                end
                RUN: begin
                    count_q <= count_q + 1'b1;
                    if (retire_fire_i && success_hit_i) begin
                        state_q <= STOPPED;
                    end
                end
                default: begin
                    // held here until the next soft reset
                    state_q <= STOPPED;
                end
            endcase
        end
    end

    assign core_reset_o  = core_reset_q;
    assign run_en_o      = (state_q == RUN);
    assign stop_o        = (state_q == STOPPED);
    assign cycle_count_o = count_q;

    // a stop is only entered from a running core
    assert property (@(posedge clk) disable iff (reset)
        $rose(stop_o) |-> $past(state_q) == RUN);

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   core_reset_i,
    input  logic                   run_en_i,
    input  logic [`FETCH_XLEN-1:0] initial_pc_i,
    input  fetch_pkg::redirect_t   redirect_i,
    output fetch_pkg::wb_req_t     wb_req_o,
    input  fetch_pkg::wb_rsp_t     wb_rsp_i,
    input  logic                   room_i,
    output logic                   push_valid_o,
    output fetch_pkg::fetch_item_t push_item_o
);

    logic [`FETCH_XLEN-1:0] pc_q;
    logic [`FETCH_XLEN-1:0] adr_q;
    logic                   busy_q;
    logic                   discard_q;
    logic                   done;
    logic                   issue;

    assign done  = busy_q & wb_rsp_i.ack;
    assign issue = ~busy_q & run_en_i & room_i & ~redirect_i.valid;

    always_ff @(posedge clk) begin
        if (core_reset_i) begin
            pc_q      <= initial_pc_i;
            busy_q    <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            if (issue) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
            // jump target wins over the step
            if (redirect_i.valid) begin
                pc_q <= redirect_i.target;
            end else if (done && !discard_q) begin
                pc_q <= pc_q + `FETCH_XLEN'(`FETCH_INSTR_BYTES);
            end
            // read in flight belongs to the old path
            if (done) begin
                discard_q <= 1'b0;
            end else if (busy_q && redirect_i.valid) begin
                discard_q <= 1'b1;
            end
        end
    end

    // address stays put for the whole read
    always_ff @(posedge clk) begin
        if (issue) begin
            adr_q <= pc_q;
        end
    end

    assign wb_req_o.cyc = busy_q;
    assign wb_req_o.stb = busy_q;
    assign wb_req_o.adr = adr_q;

    assign push_valid_o      = done & ~discard_q & ~redirect_i.valid;
    assign push_item_o.pc    = adr_q;
    assign push_item_o.instr = wb_rsp_i.dat;

    assert property (@(posedge clk) disable iff (core_reset_i)
        wb_req_o.stb && !wb_rsp_i.ack |=> wb_req_o.stb && $stable(wb_req_o.adr));

endmodule

`default_nettype wire

/* source/imem_bridge.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_defs.svh"

module imem_bridge (
    input  logic                   clk,
    input  logic                   core_reset_i,
    input  fetch_pkg::wb_req_t     wb_req_i,
    output fetch_pkg::wb_rsp_t     wb_rsp_o,
    output logic                   ins_mem_en_o,
    output logic [`FETCH_XLEN-1:0] ins_mem_addr_o,
    input  logic [`FETCH_XLEN-1:0] ins_mem_dout_i
);

    localparam int GRANT_LAST = `FETCH_GRANT_CYCLES - 1;
    localparam int ACK_LAST   = `FETCH_GRANT_CYCLES + `FETCH_WAIT_CYCLES - 1;
    localparam int CNT_W      = $clog2(ACK_LAST + 2);

    logic             active;
    logic [CNT_W-1:0] cnt_q;
    logic             en_q;
    logic             ack_q;

    assign active = wb_req_i.cyc & wb_req_i.stb;

    // one counter covers grant and wait
    // it holds the cycle number since stb rose
    always_ff @(posedge clk) begin
        if (core_reset_i) begin
            cnt_q <= '0;
            en_q  <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            if (active && !ack_q) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
            en_q  <= active && !ack_q && (cnt_q == CNT_W'(GRANT_LAST));
            ack_q <= active && (cnt_q == CNT_W'(ACK_LAST));
        end
    end

    assign ins_mem_en_o   = en_q;
    assign ins_mem_addr_o = wb_req_i.adr;

    // RAM output is still held from the enable pulse
    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = ins_mem_dout_i;

    assert property (@(posedge clk) disable iff (core_reset_i)
        wb_rsp_o.ack |=> !wb_rsp_o.ack);

endmodule

`default_nettype wire

/* source/fetch_queue.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_queue (
    input  logic                   clk,
    input  logic                   core_reset_i,
    input  logic                   flush_i,
    input  logic                   push_valid_i,
    input  fetch_pkg::fetch_item_t push_item_i,
    output logic                   room_o,
    output logic                   head_valid_o,
    output fetch_pkg::fetch_item_t head_item_o,
    input  logic                   head_ready_i
);
    import fetch_pkg::*;

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    fetch_item_t      mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             pop;

    // wraps at DEPTH so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop = head_valid_o & head_ready_i;

    always_ff @(posedge clk) begin
        if (core_reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_valid_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push_valid_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_valid_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_valid_i) begin
            mem_q[wr_ptr_q] <= push_item_i;
        end
    end

    assign room_o       = (count_q != (PTR_W + 1)'(DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_item_o  = mem_q[rd_ptr_q];

    // fetch only starts a read with a free slot
    assert property (@(posedge clk) disable iff (core_reset_i)
        push_valid_i |-> count_q != (PTR_W + 1)'(DEPTH));

endmodule

`default_nettype wire

/* source/retire_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_defs.svh"

module retire_unit (
    input  logic                   clk,
    input  logic                   core_reset_i,
    input  logic                   run_en_i,
    input  logic                   head_valid_i,
    input  fetch_pkg::fetch_item_t head_item_i,
    output logic                   head_ready_o,
    input  logic [`FETCH_XLEN-1:0] success_code_i,
    output logic                   retire_valid_o,
    output fetch_pkg::fetch_item_t retire_item_o,
    input  logic                   retire_ready_i,
    output fetch_pkg::redirect_t   redirect_o,
    output logic                   retire_fire_o,
    output logic                   success_hit_o
);
    import fetch_pkg::*;

    fetch_item_t            item_q;
    logic                   valid_q;
    opcode_e                opcode;
    logic                   is_jal;
    logic                   is_marker;
    logic                   fire;
    logic                   accept;
    logic [`FETCH_XLEN-1:0] jal_imm;

    assign opcode    = opcode_e'(item_q.instr[6:0]);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_marker = (item_q.instr == success_code_i);
    assign fire      = valid_q & retire_ready_i;

    // J-type immediate
    assign jal_imm = {{12{item_q.instr[31]}}, item_q.instr[19:12], item_q.instr[20],
                      item_q.instr[30:21], 1'b0};

    // no refill behind a jump or the marker
    // the head is younger and goes away with the flush or the stop
    assign head_ready_o = run_en_i & (~valid_q | (fire & ~is_jal & ~is_marker));
    assign accept       = head_valid_i & head_ready_o;

    always_ff @(posedge clk) begin
        if (core_reset_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (fire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            item_q <= head_item_i;
        end
    end

    assign retire_valid_o    = valid_q;
    assign retire_item_o     = item_q;
    assign retire_fire_o     = fire;
    assign success_hit_o     = valid_q & is_marker;
    assign redirect_o.valid  = fire & is_jal;
    assign redirect_o.target = item_q.pc + jal_imm;

endmodule

`default_nettype wire

/* source/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`FETCH_XLEN-1:0] ctrl_i,
    input  logic [`FETCH_XLEN-1:0] initial_pc_i,
    input  logic [`FETCH_XLEN-1:0] success_code_i,
    output logic                   ins_mem_en_o,
    output logic [`FETCH_XLEN-1:0] ins_mem_addr_o,
    input  logic [`FETCH_XLEN-1:0] ins_mem_dout_i,
    output logic                   retire_valid_o,
    output fetch_pkg::fetch_item_t retire_item_o,
    input  logic                   retire_ready_i,
    output logic                   stop_o,
    output logic [`FETCH_XLEN-1:0] cycle_count_o
);
    import fetch_pkg::*;

    logic        core_reset;
    logic        run_en;
    logic        retire_fire;
    logic        success_hit;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    redirect_t   redirect;
    logic        room;
    logic        push_valid;
    fetch_item_t push_item;
    logic        head_valid;
    logic        head_ready;
    fetch_item_t head_item;

    run_control u_run_control (
        .clk           (clk),
        .reset         (reset),
        .ctrl_i        (ctrl_i),
        .retire_fire_i (retire_fire),
        .success_hit_i (success_hit),
        .core_reset_o  (core_reset),
        .run_en_o      (run_en),
        .stop_o        (stop_o),
        .cycle_count_o (cycle_count_o)
    );

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .core_reset_i (core_reset),
        .run_en_i     (run_en),
        .initial_pc_i (initial_pc_i),
        .redirect_i   (redirect),
        .wb_req_o     (wb_req),
        .wb_rsp_i     (wb_rsp),
        .room_i       (room),
        .push_valid_o (push_valid),
        .push_item_o  (push_item)
    );

    imem_bridge u_imem_bridge (
        .clk            (clk),
        .core_reset_i   (core_reset),
        .wb_req_i       (wb_req),
        .wb_rsp_o       (wb_rsp),
        .ins_mem_en_o   (ins_mem_en_o),
        .ins_mem_addr_o (ins_mem_addr_o),
        .ins_mem_dout_i (ins_mem_dout_i)
    );

    // a taken jump empties the queue
    fetch_queue u_fetch_queue (
        .clk          (clk),
        .core_reset_i (core_reset),
        .flush_i      (redirect.valid),
        .push_valid_i (push_valid),
        .push_item_i  (push_item),
        .room_o       (room),
        .head_valid_o (head_valid),
        .head_item_o  (head_item),
        .head_ready_i (head_ready)
    );

    retire_unit u_retire_unit (
        .clk            (clk),
        .core_reset_i   (core_reset),
        .run_en_i       (run_en),
        .head_valid_i   (head_valid),
        .head_item_i    (head_item),
        .head_ready_o   (head_ready),
        .success_code_i (success_code_i),
        .retire_valid_o (retire_valid_o),
        .retire_item_o  (retire_item_o),
        .retire_ready_i (retire_ready_i),
        .redirect_o     (redirect),
        .retire_fire_o  (retire_fire),
        .success_hit_o  (success_hit)
    );

endmodule

`default_nettype wire

/* sim/tb_fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_defs.svh"

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int          NUM_TESTS   = 6;
    localparam int          CLK_HALF    = 50;
    localparam int          READ_CYCLES = `FETCH_GRANT_CYCLES + `FETCH_WAIT_CYCLES + 2;
    localparam logic [31:0] MARKER      = 32'h0000_0073;

    // one row of the test table
    typedef struct packed {
        logic [31:0] init_pc;
        logic [1:0]  prog;
        logic        rand_ready;
        logic [7:0]  max_retires;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] ctrl_i;
    logic [31:0] initial_pc_i;
    logic [31:0] success_code_i;
    logic        ins_mem_en_o;
    logic [31:0] ins_mem_addr_o;
    logic [31:0] mem_dout = '0;
    logic        retire_valid_o;
    fetch_item_t retire_item_o;
    logic        retire_ready_i;
    logic        stop_o;
    logic [31:0] cycle_count_o;

    row_t        tests [NUM_TESTS];
    string       test_names [NUM_TESTS];
    logic [31:0] prog_mem [256];
    fetch_item_t exp_q [$];
    logic [31:0] lcg_state = 32'd56;

    fetch_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .ctrl_i         (ctrl_i),
        .initial_pc_i   (initial_pc_i),
        .success_code_i (success_code_i),
        .ins_mem_en_o   (ins_mem_en_o),
        .ins_mem_addr_o (ins_mem_addr_o),
        .ins_mem_dout_i (mem_dout),
        .retire_valid_o (retire_valid_o),
        .retire_item_o  (retire_item_o),
        .retire_ready_i (retire_ready_i),
        .stop_o         (stop_o),
        .cycle_count_o  (cycle_count_o)
    );

    always #CLK_HALF clk = ~clk;

    // instruction RAM, one cycle read latency
    always @(posedge clk) begin
        if (ins_mem_en_o) begin
            mem_dout <= prog_mem[ins_mem_addr_o[9:2]];
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_item(input string name, input fetch_item_t exp, input fetch_item_t act);
        if (exp !== act) begin
            report_failure($sformatf(
                "error %s: retired item expected pc %h instr %h actual pc %h instr %h",
                name, exp.pc, exp.instr, act.pc, act.instr));
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (exp !== act) begin
            report_failure($sformatf("error %s: %s expected %b actual %b", name, what, exp, act));
        end
    endtask

    task automatic check_count(input string name, input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            report_failure($sformatf("error %s: %s expected %0d actual %0d", name, what, exp, act));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // never a JAL, never the marker
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return ((addr * 32'h9E37_79B9) & 32'hFFFF_FF80) | 32'h0000_0013;
    endfunction

    // J-type encoding with rd = x1
    function automatic logic [31:0] jal_word(input int offset);
        logic [20:0] imm;
        imm = offset[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        logic [20:0] imm;
        imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        return 32'($signed(imm));
    endfunction

    task automatic load_table();
        test_names[0] = "straight";
        tests[0]      = '{32'h100, 2'd0, 1'b0, 8'd16};
        test_names[1] = "jump";
        tests[1]      = '{32'h200, 2'd1, 1'b0, 8'd16};
        test_names[2] = "straight_random";
        tests[2]      = '{32'h040, 2'd0, 1'b1, 8'd16};
        test_names[3] = "jump_random";
        tests[3]      = '{32'h300, 2'd1, 1'b1, 8'd16};
        test_names[4] = "long_random";
        tests[4]      = '{32'h080, 2'd2, 1'b1, 8'd32};
        test_names[5] = "restart";
        tests[5]      = '{32'h100, 2'd0, 1'b0, 8'd16};
    endtask

    task automatic load_program(input logic [1:0] sel, input logic [31:0] base);
        for (int i = 0; i < 256; i++) begin
            prog_mem[i] = fill_word(32'(i) << 2);
        end
        case (sel)
            2'd0: begin
                prog_mem[(base + 32'd24) >> 2] = MARKER;
            end
            2'd1: begin
                // forward jump, then back into the skipped block
                prog_mem[(base + 32'd4) >> 2]  = jal_word(40);
                prog_mem[(base + 32'd44) >> 2] = jal_word(-32);
                prog_mem[(base + 32'd20) >> 2] = MARKER;
            end
            default: begin
                prog_mem[(base + 32'd36) >> 2] = jal_word(20);
                prog_mem[(base + 32'd68) >> 2] = MARKER;
            end
        endcase
    endtask

    // reference walk over the program
    task automatic build_expected(input logic [31:0] start_pc, input int limit);
        logic [31:0] pc;
        logic [31:0] word;
        fetch_item_t item;
        exp_q.delete();
        pc   = start_pc;
        word = '0;
        while (word != MARKER && exp_q.size() < limit) begin
            word       = prog_mem[pc[9:2]];
            item.pc    = pc;
            item.instr = word;
            exp_q.push_back(item);
            if (word[6:0] == OPC_JAL) begin
                pc = pc + jal_offset(word);
            end else begin
                pc = pc + 32'(`FETCH_INSTR_BYTES);
            end
        end
        if (word != MARKER) begin
            report_failure("reference program did not reach the marker within the retire limit");
        end
    endtask

    task automatic run_row(input int idx);
        string       name;
        row_t        row;
        int          n_done;
        int          n_cycles;
        logic        ready;
        logic [31:0] rnd;
        logic [31:0] exp_count;
        name = test_names[idx];
        row  = tests[idx];
        // soft reset, then start
        initial_pc_i = row.init_pc;
        ctrl_i       = 32'(1) << `FETCH_CTRL_RESET_BIT;
        repeat (3) @(negedge clk);
        ctrl_i = '0;
        load_program(row.prog, row.init_pc);
        build_expected(row.init_pc, row.max_retires);
        check_flag(name, "stop_o after soft reset", 1'b0, stop_o);
        check_flag(name, "retire_valid_o after soft reset", 1'b0, retire_valid_o);
        check_count(name, "cycle_count_o after soft reset", 32'd0, cycle_count_o);
        @(negedge clk);
        ctrl_i = 32'(1) << `FETCH_CTRL_START_BIT;
        n_done   = 0;
        n_cycles = 0;
        while (n_done < exp_q.size()) begin
            @(negedge clk);
            n_cycles++;
            check_flag(name, "stop_o before marker", 1'b0, stop_o);
            rnd            = lcg_next();
            ready          = row.rand_ready ? rnd[16] : 1'b1;
            retire_ready_i = ready;
            // transfer happens at the coming rising edge
            if (retire_valid_o && ready) begin
                check_item(name, exp_q[n_done], retire_item_o);
                n_done++;
            end
        end
        // start pulse and run entry take two edges, then one count per edge up to the marker
        exp_count = 32'(n_cycles - 1);
        @(negedge clk);
        retire_ready_i = 1'b1;
        check_flag(name, "stop_o after marker", 1'b1, stop_o);
        check_count(name, "cycle_count_o at stop", exp_count, cycle_count_o);
        repeat (8) begin
            @(negedge clk);
            check_flag(name, "retire_valid_o after stop", 1'b0, retire_valid_o);
            check_flag(name, "stop_o held", 1'b1, stop_o);
            check_count(name, "cycle_count_o frozen", exp_count, cycle_count_o);
        end
    endtask

    initial begin : main
        reset          = 1'b1;
        ctrl_i         = '0;
        initial_pc_i   = '0;
        success_code_i = MARKER;
        retire_ready_i = 1'b0;
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // idle before any start
        repeat (5) begin
            @(negedge clk);
            check_flag("reset_idle", "retire_valid_o", 1'b0, retire_valid_o);
            check_flag("reset_idle", "stop_o", 1'b0, stop_o);
            check_flag("reset_idle", "ins_mem_en_o", 1'b0, ins_mem_en_o);
            check_count("reset_idle", "cycle_count_o", 32'd0, cycle_count_o);
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_row(i);
        end
        $display("test passed");
        $finish;
    end

    initial begin : watchdog
        longint budget;
        @(posedge clk);
        budget = 100;
        for (int i = 0; i < NUM_TESTS; i++) begin
            budget += longint'(tests[i].max_retires) * READ_CYCLES * 4 + 20;
        end
        repeat (budget) @(posedge clk);
        report_failure("watchdog expired before all tests finished");
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
source/fetch_pkg.sv
source/run_control.sv
source/fetch_unit.sv
source/imem_bridge.sv
source/fetch_queue.sv
source/retire_unit.sv
source/fetch_top.sv
sim/tb_fetch_top.sv
